// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = sv32_mmu_tb
FILELIST  = sv32_mmu.f
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only when the simulation prints the pass line
run: compile
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)

// ==== source/memory_access.sv ====
// memory access: issues the translated access or reports the fault, bare mode passes through
module memory_access
    import sv32_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   paging_on,
    input  logic   capture_ready,
    input  logic   preq_valid,
    input  addr_t  preq_addr,
    input  logic   preq_wen,
    input  word_t  preq_wdata,
    input  wmask_t preq_wmask,
    input  logic   held_wen,
    input  word_t  held_wdata,
    input  wmask_t held_wmask,
    input  logic   walk_done,
    input  logic   walk_fault,
    input  fault_t walk_errty,
    input  addr_t  phys_addr,
    input  logic   memreq_ready,
    input  logic   memresp_valid,
    input  word_t  memresp_rdata,
    input  logic   memresp_error,
    input  fault_t memresp_errty,
    output logic   preq_ready,
    output logic   memreq_valid,
    output addr_t  memreq_addr,
    output logic   memreq_wen,
    output word_t  memreq_wdata,
    output wmask_t memreq_wmask,
    output logic   presp_valid,
    output word_t  presp_rdata,
    output logic   presp_error,
    output fault_t presp_errty,
    output logic   txn_end
);

    typedef enum logic [1:0] {
        acc_idle,
        acc_req,
        acc_wait,
        acc_resp
    } acc_state_t;

    acc_state_t state;
    word_t      result_rdata;
    logic       result_error;
    fault_t     result_errty;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= acc_idle;
        end else begin
            case (state)
                acc_idle: begin
                    if (walk_done) begin
                        if (walk_fault) begin
                            // skip memory, answer with the walk fault
                            result_rdata <= '0;
                            result_error <= 1'b1;
                            result_errty <= walk_errty;
                            state        <= acc_resp;
                        end else begin
                            state <= acc_req;
                        end
                    end
                end
                acc_req: begin
                    if (memreq_ready) begin
                        state <= acc_wait;
                    end
                end
                acc_wait: begin
                    if (memresp_valid) begin
                        result_rdata <= memresp_rdata;
                        result_error <= memresp_error;
                        result_errty <= memresp_errty;
                        state        <= acc_resp;
                    end
                end
                acc_resp: state <= acc_idle;
                default:  state <= acc_idle;
            endcase
        end
    end

    assign txn_end = (state == acc_resp);

    // bare mode is a straight connection
    assign preq_ready   = paging_on ? capture_ready : memreq_ready;
    assign memreq_valid = paging_on ? (state == acc_req) : preq_valid;
    assign memreq_addr  = paging_on ? phys_addr : preq_addr;
    assign memreq_wen   = paging_on ? held_wen : preq_wen;
    assign memreq_wdata = paging_on ? held_wdata : preq_wdata;
    assign memreq_wmask = paging_on ? held_wmask : preq_wmask;

    assign presp_valid  = paging_on ? txn_end : memresp_valid;
    assign presp_rdata  = paging_on ? result_rdata : memresp_rdata;
    assign presp_error  = paging_on ? result_error : memresp_error;
    assign presp_errty  = paging_on ? result_errty : memresp_errty;

    // translated fields come from the walker and capture, held until memory takes them
    assert property (@(posedge clk) disable iff (reset || !paging_on)
        memreq_valid && !memreq_ready |=> memreq_valid && $stable(memreq_addr)
            && $stable(memreq_wen) && $stable(memreq_wdata) && $stable(memreq_wmask))
        else $error("memory request withdrawn or changed before ready");

endmodule

// ==== source/page_walker.sv ====
// page walker: two-level sv32 walk over the pte read port, forms the physical address
module page_walker
    import sv32_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       walk_start,
    input  word_t      satp,
    input  addr_t      held_addr,
    input  logic       held_wen,
    input  priv_mode_t mode,
    input  logic       sum,
    input  logic       mxr,
    input  logic       txn_end,
    input  logic       ptereq_ready,
    input  logic       pteresp_valid,
    input  word_t      pteresp_rdata,
    input  logic       pteresp_error,
    output logic       ptereq_valid,
    output addr_t      ptereq_addr,
    output logic       walk_done,
    output logic       walk_fault,
    output fault_t     walk_errty,
    output addr_t      phys_addr
);

    typedef enum logic [1:0] {
        walk_idle,
        walk_req,
        walk_resp,
        walk_hold
    } walk_state_t;

    walk_state_t state;
    logic        level;
    addr_t       pte_addr;
    addr_t       leaf_addr;
    vpn_part_t   vpn1;
    vpn_part_t   vpn0;
    ppn_t        satp_ppn;
    ppn_t        pte_ppn;
    logic        is_leaf;
    logic        page_fault;
    logic [page_offset_width-1:0] offset;

    // table base is page aligned, so base + index * 4 is a concatenation
    function automatic addr_t table_entry(input ppn_t ppn, input vpn_part_t index);
        table_entry = {ppn[$bits(addr_t)-page_offset_width-1:0], index,
                       {pte_size_log2{1'b0}}};
    endfunction

    assign vpn1     = held_addr[$bits(addr_t)-1 -: vpn_part_width];
    assign vpn0     = held_addr[page_offset_width +: vpn_part_width];
    assign offset   = held_addr[page_offset_width-1:0];
    assign satp_ppn = satp[satp_ppn_width-1:0];
    assign pte_ppn  = pteresp_rdata[$bits(word_t)-1:ppn0_lsb];

    // superpage keeps vpn0 from the virtual address
    assign leaf_addr = level
        ? {pteresp_rdata[ppn1_lsb +: vpn_part_width], vpn0, offset}
        : {pte_ppn[$bits(addr_t)-page_offset_width-1:0], offset};

    pte_fault_check pte_check (
        .pte        (pteresp_rdata),
        .level      (level),
        .wen        (held_wen),
        .mode       (mode),
        .sum        (sum),
        .mxr        (mxr),
        .is_leaf    (is_leaf),
        .page_fault (page_fault)
    );

    assign ptereq_valid = (state == walk_req);
    assign ptereq_addr  = pte_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= walk_idle;
            level     <= 1'b1;
            walk_done <= 1'b0;
        end else begin
            walk_done <= 1'b0;
            case (state)
                walk_idle: begin
                    if (walk_start) begin
                        level    <= 1'b1;
                        pte_addr <= table_entry(satp_ppn, vpn1);
                        state    <= walk_req;
                    end
                end
                walk_req: begin
                    if (ptereq_ready) begin
                        state <= walk_resp;
                    end
                end
                walk_resp: begin
                    if (pteresp_valid) begin
                        if (pteresp_error || page_fault || is_leaf) begin
                            walk_done  <= 1'b1;
                            walk_fault <= pteresp_error || page_fault;
                            walk_errty <= pteresp_error ? fault_access : fault_page;
                            phys_addr  <= leaf_addr;
                            state      <= walk_hold;
                        end else begin
                            // pointer to the second level table
                            level    <= 1'b0;
                            pte_addr <= table_entry(pte_ppn, vpn0);
                            state    <= walk_req;
                        end
                    end
                end
                walk_hold: begin
                    if (txn_end) begin
                        state <= walk_idle;
                    end
                end
                default: state <= walk_idle;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        ptereq_valid && !ptereq_ready |=> ptereq_valid && $stable(ptereq_addr))
        else $error("pte request dropped or changed before ready");

endmodule

// ==== source/pte_fault_check.sv ====
// pte check: leaf detection and page fault rules for one page table entry
module pte_fault_check
    import sv32_pkg::*;
(
    input  word_t      pte,
    input  logic       level,
    input  logic       wen,
    input  priv_mode_t mode,
    input  logic       sum,
    input  logic       mxr,
    output logic       is_leaf,
    output logic       page_fault
);

    logic v, r, w, x, u, g, a, d;
    logic bad_encoding;
    logic bad_pointer;
    logic misaligned;
    logic no_access;

    assign v = pte[pte_v_bit];
    assign r = pte[pte_r_bit];
    assign w = pte[pte_w_bit];
    assign x = pte[pte_x_bit];
    assign u = pte[pte_u_bit];
    assign g = pte[pte_g_bit];
    assign a = pte[pte_a_bit];
    assign d = pte[pte_d_bit];

    // any of r, w, x set means the walk ends here
    assign is_leaf = r | w | x;

    // w without r is reserved, global mappings are not supported
    assign bad_encoding = !v || (w && !r) || g;
    // pointer needs a, d, u clear and must not sit at the last level
    assign bad_pointer  = !is_leaf && ((a || d || u) || !level);
    // superpage needs ppn0 all zero
    assign misaligned   = is_leaf && level && (pte[ppn1_lsb-1:ppn0_lsb] != '0);
    assign no_access    = is_leaf && (!a
                        || (wen && (!w || !d))
                        || (!wen && !r && !(mxr && x))
                        || (mode == s_mode && u && !sum));

    assign page_fault = bad_encoding || bad_pointer || misaligned || no_access;

endmodule

// ==== source/request_capture.sv ====
// request capture: decides paging mode, accepts one request and holds it during the walk
module request_capture
    import sv32_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  priv_mode_t mode,
    input  word_t      satp,
    input  logic       preq_valid,
    input  addr_t      preq_addr,
    input  logic       preq_wen,
    input  word_t      preq_wdata,
    input  wmask_t     preq_wmask,
    input  logic       txn_end,
    output logic       paging_on,
    output logic       capture_ready,
    output logic       walk_start,
    output addr_t      held_addr,
    output logic       held_wen,
    output word_t      held_wdata,
    output wmask_t     held_wmask
);

    logic busy;
    logic accept;

    // machine mode never translates
    assign paging_on     = (mode != m_mode) && satp[satp_mode_bit];
    assign capture_ready = !busy;
    assign accept        = paging_on && preq_valid && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            walk_start <= 1'b0;
        end else begin
            walk_start <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (txn_end) begin
                busy <= 1'b0;
            end
        end
    end

    // request fields stay put until the response goes out
    always_ff @(posedge clk) begin
        if (accept) begin
            held_addr  <= preq_addr;
            held_wen   <= preq_wen;
            held_wdata <= preq_wdata;
            held_wmask <= preq_wmask;
        end
    end

    // end of transaction only for a request that was accepted
    assert property (@(posedge clk) disable iff (reset) txn_end |-> busy)
        else $error("txn_end while request capture is idle");

endmodule

// ==== source/sv32_mmu.sv ====
// sv32 mmu top: translation unit for one data port of the core
module sv32_mmu
    import sv32_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  priv_mode_t mode,
    input  word_t      satp,
    input  logic       sum,
    input  logic       mxr,
    // processor side
    input  logic       preq_valid,
    input  addr_t      preq_addr,
    input  logic       preq_wen,
    input  word_t      preq_wdata,
    input  wmask_t     preq_wmask,
    output logic       preq_ready,
    output logic       presp_valid,
    output word_t      presp_rdata,
    output logic       presp_error,
    output fault_t     presp_errty,
    // memory side
    output logic       memreq_valid,
    output addr_t      memreq_addr,
    output logic       memreq_wen,
    output word_t      memreq_wdata,
    output wmask_t     memreq_wmask,
    input  logic       memreq_ready,
    input  logic       memresp_valid,
    input  word_t      memresp_rdata,
    input  logic       memresp_error,
    input  fault_t     memresp_errty,
    // page table side
    output logic       ptereq_valid,
    output addr_t      ptereq_addr,
    input  logic       ptereq_ready,
    input  logic       pteresp_valid,
    input  word_t      pteresp_rdata,
    input  logic       pteresp_error
);

    logic   paging_on;
    logic   capture_ready;
    logic   walk_start;
    addr_t  held_addr;
    logic   held_wen;
    word_t  held_wdata;
    wmask_t held_wmask;
    logic   walk_done;
    logic   walk_fault;
    fault_t walk_errty;
    addr_t  phys_addr;
    logic   txn_end;

    request_capture capture (
        .clk(clk), .reset(reset), .mode(mode), .satp(satp),
        .preq_valid(preq_valid), .preq_addr(preq_addr), .preq_wen(preq_wen),
        .preq_wdata(preq_wdata), .preq_wmask(preq_wmask), .txn_end(txn_end),
        .paging_on(paging_on), .capture_ready(capture_ready), .walk_start(walk_start),
        .held_addr(held_addr), .held_wen(held_wen), .held_wdata(held_wdata),
        .held_wmask(held_wmask)
    );

    page_walker walker (
        .clk(clk), .reset(reset), .walk_start(walk_start), .satp(satp),
        .held_addr(held_addr), .held_wen(held_wen), .mode(mode), .sum(sum), .mxr(mxr),
        .txn_end(txn_end), .ptereq_ready(ptereq_ready), .pteresp_valid(pteresp_valid),
        .pteresp_rdata(pteresp_rdata), .pteresp_error(pteresp_error),
        .ptereq_valid(ptereq_valid), .ptereq_addr(ptereq_addr), .walk_done(walk_done),
        .walk_fault(walk_fault), .walk_errty(walk_errty), .phys_addr(phys_addr)
    );

    memory_access access (
        .clk(clk), .reset(reset), .paging_on(paging_on), .capture_ready(capture_ready),
        .preq_valid(preq_valid), .preq_addr(preq_addr), .preq_wen(preq_wen),
        .preq_wdata(preq_wdata), .preq_wmask(preq_wmask), .held_wen(held_wen),
        .held_wdata(held_wdata), .held_wmask(held_wmask), .walk_done(walk_done),
        .walk_fault(walk_fault), .walk_errty(walk_errty), .phys_addr(phys_addr),
        .memreq_ready(memreq_ready), .memresp_valid(memresp_valid),
        .memresp_rdata(memresp_rdata), .memresp_error(memresp_error),
        .memresp_errty(memresp_errty), .preq_ready(preq_ready),
        .memreq_valid(memreq_valid), .memreq_addr(memreq_addr), .memreq_wen(memreq_wen),
        .memreq_wdata(memreq_wdata), .memreq_wmask(memreq_wmask),
        .presp_valid(presp_valid), .presp_rdata(presp_rdata), .presp_error(presp_error),
        .presp_errty(presp_errty), .txn_end(txn_end)
    );

endmodule

// ==== source/sv32_pkg.sv ====
// sv32 translation unit shared types, widths and bit positions
package sv32_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  wmask_t;
    typedef logic [21:0] ppn_t;
    typedef logic [9:0]  vpn_part_t;

    typedef enum logic [1:0] {
        u_mode = 2'b00,
        s_mode = 2'b01,
        m_mode = 2'b11
    } priv_mode_t;

    typedef enum logic {
        fault_access = 1'b0,
        fault_page   = 1'b1
    } fault_t;

    // 4 KiB pages, two levels of 1024 entries
    localparam int page_offset_width = 12;
    localparam int vpn_part_width    = 10;
    localparam int pte_size_log2     = 2;

    // satp is MODE | ASID | PPN
    localparam int satp_mode_bit  = 31;
    localparam int satp_ppn_width = 22;

    // pte flag bits
    localparam int pte_v_bit = 0;
    localparam int pte_r_bit = 1;
    localparam int pte_w_bit = 2;
    localparam int pte_x_bit = 3;
    localparam int pte_u_bit = 4;
    localparam int pte_g_bit = 5;
    localparam int pte_a_bit = 6;
    localparam int pte_d_bit = 7;

    // pte ppn fields
    localparam int ppn0_lsb = 10;
    localparam int ppn1_lsb = 20;

endpackage

// ==== sv32_mmu.f ====
source/sv32_pkg.sv
source/request_capture.sv
source/pte_fault_check.sv
source/page_walker.sv
source/memory_access.sv
source/sv32_mmu.sv
tb/sv32_mmu_tb.sv

// ==== tb/sv32_mmu_tb.sv ====
// sv32 mmu testbench: directed translation tests against page table and memory models
module sv32_mmu_tb;
    import sv32_pkg::*;

    localparam int timeout_cycles = 300;
    localparam ppn_t root_ppn = 22'h000100;

    // pte flag bytes
    localparam logic [7:0] flag_v = 8'h01;
    localparam logic [7:0] flag_r = 8'h02;
    localparam logic [7:0] flag_w = 8'h04;
    localparam logic [7:0] flag_x = 8'h08;
    localparam logic [7:0] flag_u = 8'h10;
    localparam logic [7:0] flag_a = 8'h40;
    localparam logic [7:0] flag_d = 8'h80;
    localparam logic [7:0] flags_rw = flag_v | flag_r | flag_w | flag_a | flag_d;

    logic       clk;
    logic       reset;
    priv_mode_t mode;
    word_t      satp;
    logic       sum;
    logic       mxr;
    logic       preq_valid;
    addr_t      preq_addr;
    logic       preq_wen;
    word_t      preq_wdata;
    wmask_t     preq_wmask;
    logic       preq_ready;
    logic       presp_valid;
    word_t      presp_rdata;
    logic       presp_error;
    fault_t     presp_errty;
    logic       memreq_valid;
    addr_t      memreq_addr;
    logic       memreq_wen;
    word_t      memreq_wdata;
    wmask_t     memreq_wmask;
    logic       memreq_ready;
    logic       memresp_valid;
    word_t      memresp_rdata;
    logic       memresp_error;
    fault_t     memresp_errty;
    logic       ptereq_valid;
    addr_t      ptereq_addr;
    logic       ptereq_ready;
    logic       pteresp_valid;
    word_t      pteresp_rdata;
    logic       pteresp_error;

    // model state
    word_t  pte_table [addr_t];
    word_t  mem [addr_t];
    word_t  rand_state;
    int     mem_count;
    addr_t  last_addr;
    logic   last_wen;
    word_t  last_wdata;
    wmask_t last_wmask;
    logic   pte_fail_on;
    addr_t  pte_fail_addr;
    logic   mem_fail_on;
    addr_t  mem_fail_addr;
    fault_t mem_fail_type;

    // last processor response
    word_t  rsp_rdata;
    logic   rsp_error;
    fault_t rsp_errty;
    int     errors;
    int     timeouts;

    sv32_mmu UUT (.*);

    always #20 clk = ~clk;

    function automatic word_t lcg_next(input word_t state);
        lcg_next = state * 32'd1664525 + 32'd1013904223;
    endfunction

    // untouched memory reads back a pattern of its own address
    function automatic word_t fill_value(input addr_t a);
        fill_value = {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic word_t mem_value(input addr_t a);
        mem_value = mem.exists(a) ? mem[a] : fill_value(a);
    endfunction

    function automatic word_t make_pte(input ppn_t ppn, input logic [7:0] flags);
        make_pte = {ppn, 2'b00, flags};
    endfunction

    function automatic addr_t table_base(input ppn_t ppn);
        table_base = addr_t'(ppn) << page_offset_width;
    endfunction

    // one second level table per vpn1
    function automatic ppn_t l2_table(input addr_t va);
        l2_table = 22'h000200 + ppn_t'(va[31:22]);
    endfunction

    function automatic addr_t l1_entry(input addr_t va);
        l1_entry = table_base(root_ppn) + addr_t'(va[31:22]) * 32'd4;
    endfunction

    function automatic addr_t l2_entry(input addr_t va);
        l2_entry = table_base(l2_table(va)) + addr_t'(va[21:12]) * 32'd4;
    endfunction

    function automatic addr_t page_pa(input addr_t va, input ppn_t ppn);
        page_pa = (addr_t'(ppn) << page_offset_width) | addr_t'(va[11:0]);
    endfunction

    // ppn1 above vpn0 and the page offset
    function automatic addr_t superpage_pa(input addr_t va, input ppn_t ppn);
        superpage_pa = (addr_t'(ppn[21:10]) << 22) | addr_t'(va[21:0]);
    endfunction

    function automatic void map_page(input addr_t va, input ppn_t ppn, input logic [7:0] flags);
        pte_table[l1_entry(va)] = make_pte(l2_table(va), flag_v);
        pte_table[l2_entry(va)] = make_pte(ppn, flags);
    endfunction

    function automatic void map_superpage(input addr_t va, input ppn_t ppn,
                                          input logic [7:0] flags);
        pte_table[l1_entry(va)] = make_pte(ppn, flags);
    endfunction

    // pte port and memory both answer one cycle after the handshake
    always @(posedge clk) begin : models
        word_t merged;
        rand_state = lcg_next(rand_state);
        ptereq_ready <= rand_state[16];
        memreq_ready <= rand_state[24];

        pteresp_valid <= ptereq_valid && ptereq_ready;
        if (ptereq_valid && ptereq_ready) begin
            pteresp_rdata <= pte_table.exists(ptereq_addr) ? pte_table[ptereq_addr] : '0;
            pteresp_error <= pte_fail_on && (ptereq_addr == pte_fail_addr);
        end

        memresp_valid <= memreq_valid && memreq_ready;
        if (memreq_valid && memreq_ready) begin
            merged = mem_value(memreq_addr);
            memresp_rdata <= merged;
            memresp_error <= mem_fail_on && (memreq_addr == mem_fail_addr);
            memresp_errty <= mem_fail_type;
            if (memreq_wen) begin
                for (int i = 0; i < 4; i++) begin
                    if (memreq_wmask[i]) begin
                        merged[8*i +: 8] = memreq_wdata[8*i +: 8];
                    end
                end
                mem[memreq_addr] = merged;
            end
            mem_count  <= mem_count + 1;
            last_addr  <= memreq_addr;
            last_wen   <= memreq_wen;
            last_wdata <= memreq_wdata;
            last_wmask <= memreq_wmask;
        end
    end

    task automatic check_value(input string test, input string what,
                               input word_t expected, input word_t actual);
        assert (actual == expected)
            else begin
                $display("[ERROR] %s: %s expected %h, actual %h", test, what, expected, actual);
                errors++;
            end
    endtask

    task automatic set_controls(input priv_mode_t m, input logic paging,
                                input logic s, input logic x);
        @(posedge clk);
        mode <= m;
        satp <= {paging, 9'd0, root_ppn};
        sum  <= s;
        mxr  <= x;
    endtask

    // one processor request, response kept in rsp_*
    task automatic transfer(input addr_t addr, input logic wen, input word_t wdata,
                            input wmask_t wmask);
        int n;
        @(posedge clk);
        preq_valid <= 1'b1;
        preq_addr  <= addr;
        preq_wen   <= wen;
        preq_wdata <= wdata;
        preq_wmask <= wmask;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!preq_ready && n < timeout_cycles);
        if (!preq_ready) begin
            $display("timeout: request to %h was never accepted", addr);
            timeouts++;
        end
        preq_valid <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!presp_valid && n < timeout_cycles);
        if (!presp_valid) begin
            $display("timeout: no response for request to %h", addr);
            timeouts++;
        end
        rsp_rdata = presp_rdata;
        rsp_error = presp_error;
        rsp_errty = presp_errty;
    endtask

    task automatic expect_access(input string test, input addr_t va, input addr_t pa,
                                 input logic wen, input word_t wdata, input wmask_t wmask);
        int    count_before;
        word_t expected_rdata;
        count_before   = mem_count;
        expected_rdata = mem_value(pa);
        transfer(va, wen, wdata, wmask);
        check_value(test, "error flag", 32'd0, 32'(rsp_error));
        check_value(test, "memory requests", 32'(count_before + 1), 32'(mem_count));
        check_value(test, "memory address", pa, last_addr);
        check_value(test, "write enable", 32'(wen), 32'(last_wen));
        if (wen) begin
            check_value(test, "write data", wdata, last_wdata);
            check_value(test, "write mask", 32'(wmask), 32'(last_wmask));
        end else begin
            check_value(test, "read data", expected_rdata, rsp_rdata);
        end
    endtask

    // a fault answers without touching memory
    task automatic expect_fault(input string test, input addr_t va, input logic wen,
                                input fault_t errty);
        int count_before;
        count_before = mem_count;
        transfer(va, wen, 32'h0bad_0bad, 4'hf);
        check_value(test, "error flag", 32'd1, 32'(rsp_error));
        check_value(test, "error type", 32'(errty), 32'(rsp_errty));
        check_value(test, "memory requests", 32'(count_before), 32'(mem_count));
    endtask

    task automatic bare_passthrough();
        set_controls(m_mode, 1'b1, 1'b0, 1'b0);
        expect_access("bare m_mode read", 32'h8001_2340, 32'h8001_2340, 1'b0, '0, '0);
        set_controls(s_mode, 1'b0, 1'b0, 1'b0);
        expect_access("bare satp off write", 32'h8001_2344, 32'h8001_2344, 1'b1,
                      32'h1357_9bdf, 4'b1011);
        expect_access("bare satp off read", 32'h8001_2344, 32'h8001_2344, 1'b0, '0, '0);
    endtask

    task automatic page_4k_translation();
        addr_t va;
        ppn_t  ppn;
        va  = 32'h0040_3a58;
        ppn = 22'h001234;
        map_page(va, ppn, flags_rw);
        set_controls(s_mode, 1'b1, 1'b0, 1'b0);
        expect_access("4k read", va, page_pa(va, ppn), 1'b0, '0, '0);
        expect_access("4k write", va, page_pa(va, ppn), 1'b1, 32'hcafe_f00d, 4'b0110);
        // u_mode may use a supervisor page here
        set_controls(u_mode, 1'b1, 1'b0, 1'b0);
        expect_access("4k u_mode read", va, page_pa(va, ppn), 1'b0, '0, '0);
    endtask

    task automatic superpage_translation();
        addr_t va;
        ppn_t  ppn;
        va  = 32'h0085_6124;
        ppn = 22'h000c00;
        map_superpage(va, ppn, flags_rw);
        set_controls(s_mode, 1'b1, 1'b0, 1'b0);
        expect_access("superpage read", va, superpage_pa(va, ppn), 1'b0, '0, '0);
        // ppn0 not zero
        map_superpage(32'h00c0_1000, 22'h000c05, flags_rw);
        expect_fault("misaligned superpage", 32'h00c0_1000, 1'b0, fault_page);
    endtask

    task automatic permission_rules();
        addr_t va;
        set_controls(s_mode, 1'b1, 1'b0, 1'b0);
        map_page(32'h0100_0010, 22'h000301, flag_v | flag_r | flag_a | flag_d);
        expect_fault("write to read-only page", 32'h0100_0010, 1'b1, fault_page);

        va = 32'h0140_2020;
        map_page(va, 22'h000302, flags_rw | flag_u);
        expect_fault("u page, sum low", va, 1'b0, fault_page);
        set_controls(s_mode, 1'b1, 1'b1, 1'b0);
        expect_access("u page, sum high", va, page_pa(va, 22'h000302), 1'b0, '0, '0);

        va = 32'h0180_3030;
        map_page(va, 22'h000303, flag_v | flag_x | flag_a);
        set_controls(s_mode, 1'b1, 1'b0, 1'b0);
        expect_fault("execute-only read, mxr low", va, 1'b0, fault_page);
        set_controls(s_mode, 1'b1, 1'b0, 1'b1);
        expect_access("execute-only read, mxr high", va, page_pa(va, 22'h000303),
                      1'b0, '0, '0);

        set_controls(s_mode, 1'b1, 1'b0, 1'b0);
        map_page(32'h01c0_4040, 22'h000304, flag_v | flag_r | flag_w | flag_d);
        expect_fault("accessed bit clear", 32'h01c0_4040, 1'b0, fault_page);
        map_page(32'h0200_5050, 22'h000305, flag_v | flag_r | flag_w | flag_a);
        expect_fault("dirty bit clear on write", 32'h0200_5050, 1'b1, fault_page);
    endtask

    task automatic error_reporting();
        addr_t va;
        int    count_before;
        set_controls(s_mode, 1'b1, 1'b0, 1'b0);
        va = 32'h0240_0abc;
        map_page(va, 22'h000401, flags_rw);
        mem_fail_addr = page_pa(va, 22'h000401);
        mem_fail_type = fault_access;
        mem_fail_on   = 1'b1;
        count_before  = mem_count;
        transfer(va, 1'b0, '0, '0);
        mem_fail_on = 1'b0;
        check_value("memory error", "error flag", 32'd1, 32'(rsp_error));
        check_value("memory error", "error type", 32'(fault_access), 32'(rsp_errty));
        check_value("memory error", "memory requests", 32'(count_before + 1), 32'(mem_count));

        // fail the second level pte read
        va = 32'h0280_5ff0;
        map_page(va, 22'h000402, flags_rw);
        pte_fail_addr = l2_entry(va);
        pte_fail_on   = 1'b1;
        expect_fault("pte access error", va, 1'b0, fault_access);
        pte_fail_on = 1'b0;
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        mode          = m_mode;
        satp          = '0;
        sum           = 1'b0;
        mxr           = 1'b0;
        preq_valid    = 1'b0;
        preq_addr     = '0;
        preq_wen      = 1'b0;
        preq_wdata    = '0;
        preq_wmask    = '0;
        memreq_ready  = 1'b0;
        memresp_valid = 1'b0;
        memresp_rdata = '0;
        memresp_error = 1'b0;
        memresp_errty = fault_access;
        ptereq_ready  = 1'b0;
        pteresp_valid = 1'b0;
        pteresp_rdata = '0;
        pteresp_error = 1'b0;
        rand_state    = 32'h72dd_4419;
        pte_fail_on   = 1'b0;
        pte_fail_addr = '0;
        mem_fail_on   = 1'b0;
        mem_fail_addr = '0;
        mem_fail_type = fault_access;

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        bare_passthrough();
        page_4k_translation();
        superpage_translation();
        permission_rules();
        error_reporting();

        repeat (2) @(posedge clk);
        $display("failed checks: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
